// File: decode_issue_top.f
+incdir+source
+incdir+sim
source/rv_pkg.sv
source/instr_decoder.sv
source/operand_lookup.sv
source/issue_ctrl.sv
source/decode_issue_top.sv
sim/tb_decode_issue.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary -j 0 --top-module tb_decode_issue -f decode_issue_top.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build error"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$log"; then
    exit 0
fi
exit 1

// File: sim/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [`XLEN-1:0] sext12(input logic [11:0] v);
    return {{(`XLEN-12){v[11]}}, v};
endfunction

// Branch with rs1 = x1 and rs2 = x2
function automatic logic [31:0] enc_branch(input logic [12:0] off, input logic [2:0] f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], opc_br};
endfunction

task automatic check_flag(input string name, input string field, input logic exp,
                          input logic act);
    if (exp !== act) begin
        $display("FAIL %s %s: expected %b, got %b", name, field, exp, act);
        errors++;
    end
endtask

task automatic check_word(input string name, input string field,
                          input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s %s: expected %h, got %h", name, field, exp, act);
        errors++;
    end
endtask

task automatic check_tag(input string name, input string field,
                         input logic [`ROB_TW-1:0] exp, input logic [`ROB_TW-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s %s: expected %0d, got %0d", name, field, exp, act);
        errors++;
    end
endtask

task automatic check_reg(input string name, input string field,
                         input logic [`REG_AW-1:0] exp, input logic [`REG_AW-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s %s: expected x%0d, got x%0d", name, field, exp, act);
        errors++;
    end
endtask

task automatic check_rob(input string name, input rv_pkg::opcode_e opcode,
                         input logic [`XLEN-1:0] pc, input logic [`REG_AW-1:0] rd);
    check_flag(name, "rob_write_o", 1'b1, rob_write_o);
    if (rob_opcode_o !== opcode) begin
        $display("FAIL %s rob_opcode_o: expected %s, got %s", name, opcode.name(),
                 rob_opcode_o.name());
        errors++;
    end
    check_word(name, "rob_pc_o", pc, rob_pc_o);
    check_reg(name, "rob_rd_o", rd, rob_rd_o);
    if (rd != '0)
        check_reg(name, "tag_rd_o", rd, tag_rd_o);
endtask

task automatic check_alu(input string name, input rv_pkg::alu_op_e op,
                         input logic [`XLEN-1:0] v1, input logic [`ROB_TW-1:0] q1,
                         input logic [`XLEN-1:0] v2, input logic [`ROB_TW-1:0] q2,
                         input logic [`ROB_TW-1:0] tag);
    check_flag(name, "alu_valid_o", 1'b1, alu_valid_o);
    check_flag(name, "cmp_valid_o", 1'b0, cmp_valid_o);
    check_flag(name, "tag_write_o", 1'b1, tag_write_o);
    if (alu_op_o !== op) begin
        $display("FAIL %s alu_op_o: expected %s, got %s", name, op.name(), alu_op_o.name());
        errors++;
    end
    check_word(name, "alu_v1_o", v1, alu_v1_o);
    check_tag(name, "alu_q1_o", q1, alu_q1_o);
    check_word(name, "alu_v2_o", v2, alu_v2_o);
    check_tag(name, "alu_q2_o", q2, alu_q2_o);
    check_tag(name, "alu_tag_o", tag, alu_tag_o);
    check_tag(name, "tag_o", tag, tag_o);
endtask

task automatic check_cmp(input string name, input rv_pkg::cmp_op_e op, input logic br,
                         input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2,
                         input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] imm);
    check_flag(name, "cmp_valid_o", 1'b1, cmp_valid_o);
    check_flag(name, "alu_valid_o", 1'b0, alu_valid_o);
    check_flag(name, "cmp_br_o", br, cmp_br_o);
    check_flag(name, "tag_write_o", !br, tag_write_o);   // Branches have no rd
    if (cmp_op_o !== op) begin
        $display("FAIL %s cmp_op_o: expected %s, got %s", name, op.name(), cmp_op_o.name());
        errors++;
    end
    check_word(name, "cmp_v1_o", v1, cmp_v1_o);
    check_tag(name, "cmp_q1_o", '0, cmp_q1_o);
    check_word(name, "cmp_v2_o", v2, cmp_v2_o);
    check_tag(name, "cmp_q2_o", '0, cmp_q2_o);
    check_tag(name, "cmp_tag_o", rob_free_tag_i, cmp_tag_o);
    if (br) begin
        check_word(name, "cmp_pc_o", pc, cmp_pc_o);
        check_word(name, "cmp_imm_o", imm, cmp_imm_o);
    end
endtask

task automatic check_idle(input string name);
    #1;
    check_flag(name, "iq_read_o", 1'b0, iq_read_o);
    check_flag(name, "rob_write_o", 1'b0, rob_write_o);
    check_flag(name, "tag_write_o", 1'b0, tag_write_o);
    check_flag(name, "alu_valid_o", 1'b0, alu_valid_o);
    check_flag(name, "cmp_valid_o", 1'b0, cmp_valid_o);
endtask

task automatic drive_head(input logic [31:0] word, input logic [`XLEN-1:0] pc);
    @(negedge clk);
    iq_instr_i = word;
    iq_pc_i    = pc;
    iq_empty_i = 1'b0;
endtask

// Returns on the falling edge after the pop with the queue empty
task automatic wait_pop(input string name);
    int n;
    n = 0;
    #1;
    while (!iq_read_o && n < TIMEOUT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!iq_read_o) begin
        $display("%s: head was not popped within %0d cycles", name, TIMEOUT);
        errors++;
    end
    @(posedge clk);
    @(negedge clk);
    iq_empty_i = 1'b1;
endtask

task automatic wait_strobe(input string name);
    int n;
    n = 0;
    while (!rob_write_o && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!rob_write_o) begin
        $display("%s: no ROB write strobe within %0d cycles", name, TIMEOUT);
        errors++;
    end else if (n != 0) begin
        $display("%s: ROB write strobe came %0d cycle(s) late", name, n);
        errors++;
    end
endtask

task automatic issue_head(input string name);
    wait_pop(name);
    wait_strobe(name);
endtask

task automatic close_test(input string name, input int start);
    tests++;
    $display("%s: %0d error(s)", name, errors - start);
endtask

task automatic alu_case(input string name, input logic [31:0] word,
                        input logic [`XLEN-1:0] pc, input rv_pkg::alu_op_e op,
                        input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2);
    drive_head(word, pc);
    issue_head(name);
    check_alu(name, op, v1, '0, v2, '0, rob_free_tag_i);
    check_rob(name, rv_pkg::opcode_e'(word[6:0]), pc, word[11:7]);
    check_reg(name, "rs1_o", word[19:15], rs1_o);
    check_reg(name, "rs2_o", word[24:20], rs2_o);
endtask

task automatic cmp_case(input string name, input logic [31:0] word,
                        input logic [`XLEN-1:0] pc, input rv_pkg::cmp_op_e op, input logic br,
                        input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2,
                        input logic [`XLEN-1:0] imm);
    drive_head(word, pc);
    issue_head(name);
    check_cmp(name, op, br, v1, v2, pc, imm);
    check_rob(name, rv_pkg::opcode_e'(word[6:0]), pc, br ? '0 : word[11:7]);
    check_reg(name, "rs1_o", word[19:15], rs1_o);
    check_reg(name, "rs2_o", word[24:20], rs2_o);
endtask

task automatic set_block(input int which, input logic on);
    case (which)
        0: alu_full_i = on;
        1: cmp_full_i = on;
        2: rob_full_i = on;
        default: rob_free_tag_i = on ? 3'd0 : 3'd4;
    endcase
endtask

task automatic hold_case(input string name, input logic [31:0] word, input int which);
    drive_head(word, 32'h300);
    set_block(which, 1'b1);
    repeat (3) begin
        check_idle(name);
        @(negedge clk);
    end
    set_block(which, 1'b0);
    issue_head(name);
    check_flag(name, "station strobe", 1'b1, alu_valid_o | cmp_valid_o);
endtask

task automatic pop_no_issue(input string name, input logic [31:0] word);
    drive_head(word, 32'h610);
    wait_pop(name);
    check_idle(name);
endtask

task automatic test_reset();
    int start;
    start = errors;
    check_idle("reset");
    repeat (3) begin
        @(negedge clk);
        check_idle("reset");
    end
    close_test("reset", start);
endtask

task automatic test_alu();
    int start;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [31:0]      rnd;
    logic [11:0]      imm;
    start = errors;
    a = $random(seed);
    b = $random(seed);
    rnd = $random(seed);
    imm = rnd[11:0];
    @(negedge clk);
    rf_v1_i = a;
    rf_v2_i = b;
    rob_free_tag_i = 3'd5;
    alu_case("addi", {imm, 5'd1, 3'b000, 5'd3, opc_imm}, 32'h100, rv_pkg::alu_add,
             a, sext12(imm));
    alu_case("add", {7'h00, 5'd2, 5'd1, 3'b000, 5'd4, opc_reg}, 32'h104, rv_pkg::alu_add, a, b);
    alu_case("sub", {7'h20, 5'd2, 5'd1, 3'b000, 5'd4, opc_reg}, 32'h108, rv_pkg::alu_sub, a, b);
    alu_case("srai", {7'h20, 5'd7, 5'd1, 3'b101, 5'd6, opc_imm}, 32'h10c, rv_pkg::alu_sra,
             a, 32'h0000_0407);
    alu_case("srli", {7'h00, 5'd9, 5'd1, 3'b101, 5'd7, opc_imm}, 32'h110, rv_pkg::alu_srl,
             a, 32'h0000_0009);
    alu_case("lui", {20'habcde, 5'd8, opc_lui}, 32'h114, rv_pkg::alu_add, '0, 32'habcde000);
    alu_case("auipc", {20'h12345, 5'd9, opc_auipc}, 32'h118, rv_pkg::alu_add,
             32'h118, 32'h12345000);
    close_test("alu issue", start);
endtask

task automatic test_cmp();
    int start;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [31:0]      rnd;
    logic [11:0]      imm;
    start = errors;
    a = $random(seed);
    b = $random(seed);
    rnd = $random(seed);
    imm = rnd[11:0];
    rf_v1_i = a;
    rf_v2_i = b;
    rob_free_tag_i = 3'd6;
    cmp_case("slti", {imm, 5'd1, 3'b010, 5'd10, opc_imm}, 32'h500, rv_pkg::slt, 1'b0,
             a, sext12(imm), '0);
    cmp_case("sltu", {7'h00, 5'd2, 5'd1, 3'b011, 5'd11, opc_reg}, 32'h504, rv_pkg::sltu,
             1'b0, a, b, '0);
    cmp_case("beq", enc_branch(13'h0048, 3'b000), 32'h508, rv_pkg::beq, 1'b1, a, b, 32'h48);
    cmp_case("blt", enc_branch(13'h1ff0, 3'b100), 32'h50c, rv_pkg::blt, 1'b1, a, b,
             32'hffff_fff0);    // Offset -16
    close_test("cmp issue", start);
endtask

task automatic test_backpressure();
    int start;
    start = errors;
    rob_free_tag_i = 3'd4;
    hold_case("alu full", {12'h005, 5'd1, 3'b000, 5'd3, opc_imm}, 0);
    hold_case("cmp full", enc_branch(13'h0010, 3'b001), 1);
    hold_case("rob full", {12'h006, 5'd1, 3'b000, 5'd3, opc_imm}, 2);
    hold_case("no free tag", {12'h007, 5'd1, 3'b000, 5'd3, opc_imm}, 3);
    close_test("backpressure", start);
endtask

task automatic test_operands();
    int start;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] c;
    start = errors;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    rf_v1_i = a;
    rf_v2_i = b;
    rob_free_tag_i = 3'd3;
    // x5 = x1 + 1 and then x6 = x5 + x2 right behind it
    drive_head({12'h001, 5'd1, 3'b000, 5'd5, opc_imm}, 32'h400);
    wait_pop("dep first");
    wait_strobe("dep first");
    check_alu("dep first", rv_pkg::alu_add, a, '0, 32'h1, '0, 3'd3);
    iq_instr_i = {7'h00, 5'd2, 5'd5, 3'b000, 5'd6, opc_reg};
    iq_pc_i = 32'h404;
    iq_empty_i = 1'b0;
    rob_free_tag_i = 3'd4;
    issue_head("dep second");
    check_alu("dep second", rv_pkg::alu_add, '0, 3'd3, b, '0, 3'd4);
    rf_q1_i = 3'd2;     // Entry 2 done while entry 5 is still busy
    rob_rdy1_i = 1'b1;
    rob_val1_i = c;
    rf_q2_i = 3'd5;
    rob_val2_i = ~c;
    rob_free_tag_i = 3'd7;
    drive_head({7'h00, 5'd2, 5'd1, 3'b000, 5'd7, opc_reg}, 32'h408);
    issue_head("rob fwd");
    check_alu("rob fwd", rv_pkg::alu_add, c, '0, b, 3'd5, 3'd7);
    rf_q1_i = '0;
    rf_q2_i = '0;
    rob_rdy1_i = 1'b0;
    close_test("operands", start);
endtask

task automatic test_discard_flush();
    int start;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    start = errors;
    a = $random(seed);
    b = $random(seed);
    rf_v1_i = a;
    rf_v2_i = b;
    pop_no_issue("rd zero", {12'h00f, 5'd1, 3'b000, 5'd0, opc_imm});
    pop_no_issue("bad opcode", {12'h00f, 5'd1, 3'b010, 5'd5, 7'b0000011});
    drive_head({12'h002, 5'd1, 3'b000, 5'd5, opc_imm}, 32'h600);
    rob_free_tag_i = 3'd2;
    wait_pop("flush first");
    iq_instr_i = {7'h00, 5'd2, 5'd5, 3'b000, 5'd6, opc_reg};
    iq_pc_i = 32'h604;
    iq_empty_i = 1'b0;
    flush_i = 1'b1;
    rob_free_tag_i = 3'd3;
    repeat (2) begin
        @(negedge clk);
        check_idle("flush");
    end
    @(negedge clk);
    flush_i = 1'b0;
    issue_head("after flush");
    check_alu("after flush", rv_pkg::alu_add, a, '0, b, '0, 3'd3);  // x5 tag forgotten
    close_test("discard flush", start);
endtask

`endif

// File: sim/tb_decode_issue.sv
`include "rv_params.svh"

module tb_decode_issue;

    localparam int TIMEOUT = 20;

    // RV32I major opcodes
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_br    = 7'b1100011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_reg   = 7'b0110011;

    logic                clk;
    logic                rst_n_i;
    logic                flush_i;
    rv_pkg::instr_word_u iq_instr_i;
    logic [`XLEN-1:0]    iq_pc_i;
    logic                iq_empty_i;
    logic                iq_read_o;
    logic [`REG_AW-1:0]  rs1_o;
    logic [`REG_AW-1:0]  rs2_o;
    logic [`XLEN-1:0]    rf_v1_i;
    logic [`ROB_TW-1:0]  rf_q1_i;
    logic [`XLEN-1:0]    rf_v2_i;
    logic [`ROB_TW-1:0]  rf_q2_i;
    logic                rob_rdy1_i;
    logic [`XLEN-1:0]    rob_val1_i;
    logic                rob_rdy2_i;
    logic [`XLEN-1:0]    rob_val2_i;
    logic [`ROB_TW-1:0]  rob_free_tag_i;
    logic                rob_full_i;
    logic                rob_write_o;
    logic [`XLEN-1:0]    rob_pc_o;
    logic [`REG_AW-1:0]  rob_rd_o;
    rv_pkg::opcode_e     rob_opcode_o;
    logic                tag_write_o;
    logic [`REG_AW-1:0]  tag_rd_o;
    logic [`ROB_TW-1:0]  tag_o;
    logic                alu_full_i;
    logic                alu_valid_o;
    rv_pkg::alu_op_e     alu_op_o;
    logic [`XLEN-1:0]    alu_v1_o;
    logic [`ROB_TW-1:0]  alu_q1_o;
    logic [`XLEN-1:0]    alu_v2_o;
    logic [`ROB_TW-1:0]  alu_q2_o;
    logic [`ROB_TW-1:0]  alu_tag_o;
    logic                cmp_full_i;
    logic                cmp_valid_o;
    logic                cmp_br_o;
    rv_pkg::cmp_op_e     cmp_op_o;
    logic [`XLEN-1:0]    cmp_v1_o;
    logic [`ROB_TW-1:0]  cmp_q1_o;
    logic [`XLEN-1:0]    cmp_v2_o;
    logic [`ROB_TW-1:0]  cmp_q2_o;
    logic [`XLEN-1:0]    cmp_pc_o;
    logic [`XLEN-1:0]    cmp_imm_o;
    logic [`ROB_TW-1:0]  cmp_tag_o;

    int     errors;
    int     tests;
    integer seed;

    decode_issue_top UUT (.*);

    always #2 clk = ~clk;

    `include "tb_tasks.svh"

    initial begin
        seed           = 23;
        errors         = 0;
        tests          = 0;
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        iq_instr_i     = '0;
        iq_pc_i        = '0;
        iq_empty_i     = 1'b1;
        rf_v1_i        = '0;
        rf_q1_i        = '0;
        rf_v2_i        = '0;
        rf_q2_i        = '0;
        rob_rdy1_i     = 1'b0;
        rob_val1_i     = '0;
        rob_rdy2_i     = 1'b0;
        rob_val2_i     = '0;
        rob_free_tag_i = 3'd1;
        rob_full_i     = 1'b0;
        alu_full_i     = 1'b0;
        cmp_full_i     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        test_reset();
        test_alu();
        test_cmp();
        test_backpressure();
        test_operands();
        test_discard_flush();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: source/decode_issue_top.sv
`include "rv_params.svh"

module decode_issue_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    // Instruction queue
    input  rv_pkg::instr_word_u iq_instr_i,
    input  logic [`XLEN-1:0]    iq_pc_i,
    input  logic                iq_empty_i,
    output logic                iq_read_o,
    // Register file read
    output logic [`REG_AW-1:0]  rs1_o,
    output logic [`REG_AW-1:0]  rs2_o,
    input  logic [`XLEN-1:0]    rf_v1_i,
    input  logic [`ROB_TW-1:0]  rf_q1_i,
    input  logic [`XLEN-1:0]    rf_v2_i,
    input  logic [`ROB_TW-1:0]  rf_q2_i,
    // ROB
    input  logic                rob_rdy1_i,
    input  logic [`XLEN-1:0]    rob_val1_i,
    input  logic                rob_rdy2_i,
    input  logic [`XLEN-1:0]    rob_val2_i,
    input  logic [`ROB_TW-1:0]  rob_free_tag_i,
    input  logic                rob_full_i,
    output logic                rob_write_o,
    output logic [`XLEN-1:0]    rob_pc_o,
    output logic [`REG_AW-1:0]  rob_rd_o,
    output rv_pkg::opcode_e     rob_opcode_o,
    // Register file tag write
    output logic                tag_write_o,
    output logic [`REG_AW-1:0]  tag_rd_o,
    output logic [`ROB_TW-1:0]  tag_o,
    // ALU station
    input  logic                alu_full_i,
    output logic                alu_valid_o,
    output rv_pkg::alu_op_e     alu_op_o,
    output logic [`XLEN-1:0]    alu_v1_o,
    output logic [`ROB_TW-1:0]  alu_q1_o,
    output logic [`XLEN-1:0]    alu_v2_o,
    output logic [`ROB_TW-1:0]  alu_q2_o,
    output logic [`ROB_TW-1:0]  alu_tag_o,
    // Compare station
    input  logic                cmp_full_i,
    output logic                cmp_valid_o,
    output logic                cmp_br_o,
    output rv_pkg::cmp_op_e     cmp_op_o,
    output logic [`XLEN-1:0]    cmp_v1_o,
    output logic [`ROB_TW-1:0]  cmp_q1_o,
    output logic [`XLEN-1:0]    cmp_v2_o,
    output logic [`ROB_TW-1:0]  cmp_q2_o,
    output logic [`XLEN-1:0]    cmp_pc_o,
    output logic [`XLEN-1:0]    cmp_imm_o,
    output logic [`ROB_TW-1:0]  cmp_tag_o
);

    rv_pkg::opcode_e    dec_opcode;
    rv_pkg::target_e    dec_target;
    rv_pkg::alu_op_e    dec_alu_op;
    rv_pkg::cmp_op_e    dec_cmp_op;
    logic [`REG_AW-1:0] dec_rd;
    logic               use_rs2;
    logic               src1_pc;
    logic               src1_zero;
    logic [`XLEN-1:0]   dec_imm;
    logic [`XLEN-1:0]   dec_br_imm;
    logic               writes_rd;
    logic               accept;
    logic [`XLEN-1:0]   v1;
    logic [`ROB_TW-1:0] q1;
    logic [`XLEN-1:0]   v2;
    logic [`ROB_TW-1:0] q2;

    instr_decoder u_decoder (
        .instr_i(iq_instr_i), .pc_i(iq_pc_i),
        .opcode_o(dec_opcode), .target_o(dec_target),
        .alu_op_o(dec_alu_op), .cmp_op_o(dec_cmp_op),
        .rs1_o(rs1_o), .rs2_o(rs2_o), .rd_o(dec_rd),
        .use_rs2_o(use_rs2), .src1_pc_o(src1_pc), .src1_zero_o(src1_zero),
        .imm_o(dec_imm), .br_imm_o(dec_br_imm), .writes_rd_o(writes_rd)
    );

    operand_lookup u_lookup (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .accept_i(accept), .writes_rd_i(writes_rd), .rd_i(dec_rd),
        .rs1_i(rs1_o), .rs2_i(rs2_o), .new_tag_i(rob_free_tag_i),
        .rf_v1_i(rf_v1_i), .rf_q1_i(rf_q1_i), .rf_v2_i(rf_v2_i), .rf_q2_i(rf_q2_i),
        .rob_rdy1_i(rob_rdy1_i), .rob_val1_i(rob_val1_i),
        .rob_rdy2_i(rob_rdy2_i), .rob_val2_i(rob_val2_i),
        .v1_o(v1), .q1_o(q1), .v2_o(v2), .q2_o(q2)
    );

    issue_ctrl u_issue (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .iq_empty_i(iq_empty_i), .pc_i(iq_pc_i),
        .opcode_i(dec_opcode), .target_i(dec_target),
        .alu_op_i(dec_alu_op), .cmp_op_i(dec_cmp_op), .rd_i(dec_rd),
        .use_rs2_i(use_rs2), .src1_pc_i(src1_pc), .src1_zero_i(src1_zero),
        .imm_i(dec_imm), .br_imm_i(dec_br_imm), .writes_rd_i(writes_rd),
        .v1_i(v1), .q1_i(q1), .v2_i(v2), .q2_i(q2),
        .rob_free_tag_i(rob_free_tag_i), .rob_full_i(rob_full_i),
        .alu_full_i(alu_full_i), .cmp_full_i(cmp_full_i),
        .iq_read_o(iq_read_o), .accept_o(accept),
        .rob_write_o(rob_write_o), .rob_pc_o(rob_pc_o),
        .rob_rd_o(rob_rd_o), .rob_opcode_o(rob_opcode_o),
        .tag_write_o(tag_write_o), .tag_rd_o(tag_rd_o), .tag_o(tag_o),
        .alu_valid_o(alu_valid_o), .alu_op_o(alu_op_o),
        .alu_v1_o(alu_v1_o), .alu_q1_o(alu_q1_o),
        .alu_v2_o(alu_v2_o), .alu_q2_o(alu_q2_o), .alu_tag_o(alu_tag_o),
        .cmp_valid_o(cmp_valid_o), .cmp_br_o(cmp_br_o), .cmp_op_o(cmp_op_o),
        .cmp_v1_o(cmp_v1_o), .cmp_q1_o(cmp_q1_o),
        .cmp_v2_o(cmp_v2_o), .cmp_q2_o(cmp_q2_o),
        .cmp_pc_o(cmp_pc_o), .cmp_imm_o(cmp_imm_o), .cmp_tag_o(cmp_tag_o)
    );

endmodule

// File: source/instr_decoder.sv
`include "rv_params.svh"

module instr_decoder (
    input  rv_pkg::instr_word_u instr_i,
    input  logic [`XLEN-1:0]    pc_i,
    output rv_pkg::opcode_e     opcode_o,
    output rv_pkg::target_e     target_o,
    output rv_pkg::alu_op_e     alu_op_o,
    output rv_pkg::cmp_op_e     cmp_op_o,
    output logic [`REG_AW-1:0]  rs1_o,
    output logic [`REG_AW-1:0]  rs2_o,
    output logic [`REG_AW-1:0]  rd_o,
    output logic                use_rs2_o,
    output logic                src1_pc_o,
    output logic                src1_zero_o,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`XLEN-1:0]    br_imm_o,
    output logic                writes_rd_o
);

    logic [6:0]       opc;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] b_imm;

    assign opc = instr_i.r.opcode;
    assign f3  = instr_i.r.funct3;
    assign f7  = instr_i.r.funct7;

    assign rs1_o = instr_i.r.rs1;
    assign rs2_o = instr_i.r.rs2;
    assign rd_o  = instr_i.r.rd;

    assign i_imm = {{(`XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
    assign u_imm = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'h000};
    // B immediate is scattered over the funct7 and rd slots
    assign b_imm = {{(`XLEN-12){f7[6]}}, instr_i.r.rd[0], f7[5:0], instr_i.r.rd[4:1], 1'b0};

    assign opcode_o = rv_pkg::opcode_e'(opc);
    assign cmp_op_o = rv_pkg::cmp_op_e'(f3);

    always_comb begin
        target_o    = rv_pkg::tgt_none;
        alu_op_o    = rv_pkg::alu_add;
        use_rs2_o   = 1'b0;
        src1_pc_o   = 1'b0;
        src1_zero_o = 1'b0;
        imm_o       = i_imm;
        case (opc)
            rv_pkg::op_lui: begin
                target_o    = rv_pkg::tgt_alu;
                src1_zero_o = 1'b1;     // 0 + imm
                imm_o       = u_imm;
            end
            rv_pkg::op_auipc: begin
                target_o  = rv_pkg::tgt_alu;
                src1_pc_o = 1'b1;
                imm_o     = u_imm;
            end
            rv_pkg::op_br: begin
                use_rs2_o = 1'b1;
                if (f3[2:1] != 2'b01)   // 010/011 are not branches
                    target_o = rv_pkg::tgt_cmp;
            end
            rv_pkg::op_imm: begin
                if (f3[2:1] == 2'b01) begin
                    target_o = rv_pkg::tgt_cmp;
                end else begin
                    target_o = rv_pkg::tgt_alu;
                    alu_op_o = rv_pkg::alu_op_e'({f7[5] & (f3 == 3'b101), f3});
                end
            end
            rv_pkg::op_reg: begin
                use_rs2_o = 1'b1;
                if (f3[2:1] == 2'b01) begin
                    target_o = rv_pkg::tgt_cmp;
                end else begin
                    target_o = rv_pkg::tgt_alu;
                    alu_op_o = rv_pkg::alu_op_e'({f7[5] & (f3 == 3'b000 || f3 == 3'b101), f3});
                end
            end
            default: ;
        endcase
        // A misaligned fetch address can not hold a valid RV32I word
        if (pc_i[1:0] != 2'b00)
            target_o = rv_pkg::tgt_none;
    end

    assign br_imm_o = (opc == rv_pkg::op_br) ? b_imm : '0;

    assign writes_rd_o = (target_o != rv_pkg::tgt_none) && (opc != rv_pkg::op_br) &&
                         (instr_i.r.rd != '0);

endmodule

// File: source/issue_ctrl.sv
`include "rv_params.svh"

module issue_ctrl (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               iq_empty_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  rv_pkg::opcode_e    opcode_i,
    input  rv_pkg::target_e    target_i,
    input  rv_pkg::alu_op_e    alu_op_i,
    input  rv_pkg::cmp_op_e    cmp_op_i,
    input  logic [`REG_AW-1:0] rd_i,
    input  logic               use_rs2_i,
    input  logic               src1_pc_i,
    input  logic               src1_zero_i,
    input  logic [`XLEN-1:0]   imm_i,
    input  logic [`XLEN-1:0]   br_imm_i,
    input  logic               writes_rd_i,
    input  logic [`XLEN-1:0]   v1_i,
    input  logic [`ROB_TW-1:0] q1_i,
    input  logic [`XLEN-1:0]   v2_i,
    input  logic [`ROB_TW-1:0] q2_i,
    input  logic [`ROB_TW-1:0] rob_free_tag_i,
    input  logic               rob_full_i,
    input  logic               alu_full_i,
    input  logic               cmp_full_i,
    output logic               iq_read_o,
    output logic               accept_o,
    output logic               rob_write_o,
    output logic [`XLEN-1:0]   rob_pc_o,
    output logic [`REG_AW-1:0] rob_rd_o,
    output rv_pkg::opcode_e    rob_opcode_o,
    output logic               tag_write_o,
    output logic [`REG_AW-1:0] tag_rd_o,
    output logic [`ROB_TW-1:0] tag_o,
    output logic               alu_valid_o,
    output rv_pkg::alu_op_e    alu_op_o,
    output logic [`XLEN-1:0]   alu_v1_o,
    output logic [`ROB_TW-1:0] alu_q1_o,
    output logic [`XLEN-1:0]   alu_v2_o,
    output logic [`ROB_TW-1:0] alu_q2_o,
    output logic [`ROB_TW-1:0] alu_tag_o,
    output logic               cmp_valid_o,
    output logic               cmp_br_o,
    output rv_pkg::cmp_op_e    cmp_op_o,
    output logic [`XLEN-1:0]   cmp_v1_o,
    output logic [`ROB_TW-1:0] cmp_q1_o,
    output logic [`XLEN-1:0]   cmp_v2_o,
    output logic [`ROB_TW-1:0] cmp_q2_o,
    output logic [`XLEN-1:0]   cmp_pc_o,
    output logic [`XLEN-1:0]   cmp_imm_o,
    output logic [`ROB_TW-1:0] cmp_tag_o
);

    logic               is_br;
    logic               to_alu;
    logic               to_cmp;
    logic               issuable;
    logic               stn_full;
    logic               discard;
    logic [`XLEN-1:0]   op1_v;
    logic [`ROB_TW-1:0] op1_q;
    logic [`XLEN-1:0]   op2_v;
    logic [`ROB_TW-1:0] op2_q;

    assign is_br    = (opcode_i == rv_pkg::op_br);
    assign to_alu   = (target_i == rv_pkg::tgt_alu);
    assign to_cmp   = (target_i == rv_pkg::tgt_cmp);
    assign issuable = (target_i != rv_pkg::tgt_none) && (writes_rd_i || is_br);
    assign stn_full = to_alu ? alu_full_i : cmp_full_i;

    assign accept_o = !iq_empty_i && !flush_i && issuable && !rob_full_i &&
                      (rob_free_tag_i != '0) && !stn_full;
    assign discard   = !iq_empty_i && !flush_i && !issuable;   // Unknown op or rd 0
    assign iq_read_o = accept_o || discard;

    always_comb begin
        op1_v = v1_i;
        op1_q = q1_i;
        if (src1_zero_i) begin
            op1_v = '0;
            op1_q = '0;
        end else if (src1_pc_i) begin
            op1_v = pc_i;
            op1_q = '0;
        end
    end

    assign op2_v = use_rs2_i ? v2_i : imm_i;
    assign op2_q = use_rs2_i ? q2_i : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rob_write_o <= 1'b0;
            tag_write_o <= 1'b0;
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
        end else begin
            rob_write_o <= accept_o;
            tag_write_o <= accept_o && writes_rd_i;    // Branches leave the tags alone
            alu_valid_o <= accept_o && to_alu;
            cmp_valid_o <= accept_o && to_cmp;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            rob_pc_o     <= pc_i;
            rob_rd_o     <= writes_rd_i ? rd_i : '0;
            rob_opcode_o <= opcode_i;
            tag_rd_o     <= rd_i;
            tag_o        <= rob_free_tag_i;
        end
        if (accept_o && to_alu) begin
            alu_op_o  <= alu_op_i;
            alu_v1_o  <= op1_v;
            alu_q1_o  <= op1_q;
            alu_v2_o  <= op2_v;
            alu_q2_o  <= op2_q;
            alu_tag_o <= rob_free_tag_i;
        end
        if (accept_o && to_cmp) begin
            cmp_br_o  <= is_br;
            cmp_op_o  <= cmp_op_i;
            cmp_v1_o  <= op1_v;
            cmp_q1_o  <= op1_q;
            cmp_v2_o  <= op2_v;
            cmp_q2_o  <= op2_q;
            cmp_pc_o  <= pc_i;
            cmp_imm_o <= br_imm_i;
            cmp_tag_o <= rob_free_tag_i;
        end
    end

endmodule

// File: source/operand_lookup.sv
`include "rv_params.svh"

module operand_lookup (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               accept_i,
    input  logic               writes_rd_i,
    input  logic [`REG_AW-1:0] rd_i,
    input  logic [`REG_AW-1:0] rs1_i,
    input  logic [`REG_AW-1:0] rs2_i,
    input  logic [`ROB_TW-1:0] new_tag_i,
    input  logic [`XLEN-1:0]   rf_v1_i,
    input  logic [`ROB_TW-1:0] rf_q1_i,
    input  logic [`XLEN-1:0]   rf_v2_i,
    input  logic [`ROB_TW-1:0] rf_q2_i,
    input  logic               rob_rdy1_i,
    input  logic [`XLEN-1:0]   rob_val1_i,
    input  logic               rob_rdy2_i,
    input  logic [`XLEN-1:0]   rob_val2_i,
    output logic [`XLEN-1:0]   v1_o,
    output logic [`ROB_TW-1:0] q1_o,
    output logic [`XLEN-1:0]   v2_o,
    output logic [`ROB_TW-1:0] q2_o
);

    // rd 0 here means nothing was issued last cycle
    logic [`REG_AW-1:0] last_rd;
    logic [`ROB_TW-1:0] last_tag;

    // Register file gets the new tag one cycle after issue
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_rd  <= '0;
            last_tag <= '0;
        end else if (accept_i && writes_rd_i && !flush_i) begin
            last_rd  <= rd_i;
            last_tag <= new_tag_i;
        end else begin
            last_rd  <= '0;
        end
    end

    function automatic logic [`XLEN+`ROB_TW-1:0] resolve(
        input logic [`REG_AW-1:0] src,
        input logic [`XLEN-1:0]   rf_v,
        input logic [`ROB_TW-1:0] rf_q,
        input logic               rob_rdy,
        input logic [`XLEN-1:0]   rob_val
    );
        if (src != '0 && src == last_rd)
            return {{`XLEN{1'b0}}, last_tag};     // Wait on the previous issue
        else if (rf_q != '0 && rob_rdy)
            return {rob_val, {`ROB_TW{1'b0}}};    // Done but not committed
        else
            return {rf_v, rf_q};
    endfunction

    assign {v1_o, q1_o} = resolve(rs1_i, rf_v1_i, rf_q1_i, rob_rdy1_i, rob_val1_i);
    assign {v2_o, q2_o} = resolve(rs2_i, rf_v2_i, rf_q2_i, rob_rdy2_i, rob_val2_i);

endmodule

// File: source/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path and PC width
`define XLEN 32

// Architectural register address
`define REG_AW 5

// ROB tag width, 8 entries
// Tag 0 is never allocated and marks a ready operand
`define ROB_TW 3

`endif

// File: source/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    // Only the opcodes this stage issues
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // Low 3 bits follow funct3, bit 3 is funct7[5] for SUB/SRA
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        slt  = 3'b010,  // Non-branch compares sit in the unused branch codes
        sltu = 3'b011,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        tgt_none = 2'd0,
        tgt_alu  = 2'd1,
        tgt_cmp  = 2'd2
    } target_e;

    typedef union packed {
        struct packed {
            logic [6:0]         funct7;
            logic [`REG_AW-1:0] rs2;
            logic [`REG_AW-1:0] rs1;
            logic [2:0]         funct3;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } r;
        struct packed {
            logic [11:0]        imm12;
            logic [`REG_AW-1:0] rs1;
            logic [2:0]         funct3;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } i;
    } instr_word_u;

endpackage
